//--- verilog/game_pkg.sv
// space shooter shared types
package game_pkg;

	typedef logic [7:0] scan_code_t;	// one ps/2 byte

	localparam scan_code_t CODE_BREAK  = 8'hF0;	// release prefix
	localparam scan_code_t CODE_EXTEND = 8'hE0;	// arrow keys etc

	// movement keys, left hand
	localparam scan_code_t KEY_W = 8'h1D;
	localparam scan_code_t KEY_A = 8'h1C;
	localparam scan_code_t KEY_S = 8'h1B;
	localparam scan_code_t KEY_D = 8'h23;

	// arrow keys, sent after the E0 prefix
	localparam scan_code_t KEY_UP_ARROW    = 8'h75;
	localparam scan_code_t KEY_LEFT_ARROW  = 8'h6B;
	localparam scan_code_t KEY_DOWN_ARROW  = 8'h72;
	localparam scan_code_t KEY_RIGHT_ARROW = 8'h74;

	localparam scan_code_t KEY_SPACE = 8'h29;	// fire

	typedef enum logic [2:0] {
		DIR_NONE,
		DIR_UP,
		DIR_RIGHT,
		DIR_DOWN,
		DIR_LEFT
	} dir_t;

	typedef logic [2:0] colour_t;	// 1 bit per rgb channel

	localparam colour_t COLOUR_BLACK  = 3'd0;
	localparam colour_t COLOUR_SHIP   = 3'd5;	// magenta
	localparam colour_t COLOUR_BULLET = 3'd7;	// white

	typedef logic [7:0] coord_x_t;	// up to 256 columns
	typedef logic [6:0] coord_y_t;	// up to 128 rows

	localparam int FILTER_LEN  = 8;	// ps/2 clock samples that must agree
	localparam int BULLET_STEP = 2;	// bullet pixels per frame

endpackage

//--- verilog/ship_cmd_if.sv
// ship command bus
`timescale 1ns/100ps

interface ship_cmd_if
(
	input logic clock,
	input logic step	// frame pulse from the raster
);
	import game_pkg::*;

	dir_t held_dir;	// level, key currently held
	logic fire;	// one cycle per space press

	modport decoder (input clock, output held_dir, output fire);
	modport ship (input clock, input held_dir, input step);
	modport bullet (input clock, input fire, input step);

endinterface

//--- verilog/sprite_if.sv
// sprite state bus
`timescale 1ns/100ps

interface sprite_if;
	import game_pkg::*;

	coord_x_t ship_x;	// ship centre
	coord_y_t ship_y;
	dir_t facing;	// last non-idle direction
	coord_x_t bullet_x;
	coord_y_t bullet_y;
	logic bullet_active;	// bullet fields valid only while set

	modport ship_src (output ship_x, output ship_y, output facing);

	// bullet spawns from the ship, so it sees the ship fields
	modport bullet_src (
		input ship_x, input ship_y, input facing,
		output bullet_x, output bullet_y, output bullet_active
	);

	modport render (
		input ship_x, input ship_y, input facing,
		input bullet_x, input bullet_y, input bullet_active
	);

endinterface

//--- verilog/ps2_rx.sv
// ps/2 frame receiver
`timescale 1ns/100ps

module ps2_rx
(
	input  logic clock,
	input  logic reset,
	input  logic ps2_clock,	// raw keyboard clock
	input  logic ps2_data,	// raw keyboard data
	output game_pkg::scan_code_t scan_code,
	output logic scan_done	// one cycle per received byte
);
	import game_pkg::*;

	typedef enum logic {
		RX_IDLE,
		RX_FRAME
	} rx_state_t;

	logic [FILTER_LEN-1:0] filter;	// recent ps2_clock samples
	logic filt_clock;	// debounced clock level
	logic filt_next;
	logic fall;	// filtered falling edge
	rx_state_t state;
	logic [3:0] bits_left;	// data, parity and stop still to come
	logic [10:0] frame;	// start bit ends up in bit 0
	logic [10:0] frame_next;
	logic last_bit;	// stop bit being sampled now

	// level flips only once every sample agrees
	assign filt_next = (&filter) ? 1'b1 :
		(~|filter) ? 1'b0 :
		filt_clock;
	assign fall = filt_clock & ~filt_next;

	assign frame_next = {ps2_data, frame[10:1]};	// lsb first on the wire
	assign last_bit = fall && (state == RX_FRAME) && (bits_left == 4'd1);

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			filter <= '0;
			filt_clock <= 1'b0;
		end
		else
		begin
			filter <= {ps2_clock, filter[FILTER_LEN-1:1]};
			filt_clock <= filt_next;
		end
	end

	// idle waits for the start edge, then ten more edges
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state <= RX_IDLE;
			bits_left <= '0;
			scan_done <= 1'b0;
		end
		else
		begin
			scan_done <= last_bit;
			case (state)
				RX_IDLE:
					if (fall)
					begin
						state <= RX_FRAME;
						bits_left <= 4'd10;
					end
				RX_FRAME:
					if (fall)
					begin
						bits_left <= bits_left - 4'd1;
						if (bits_left == 4'd1)
							state <= RX_IDLE;	// stop bit in, frame done
					end
				default:
					state <= RX_IDLE;
			endcase
		end
	end

	// data path, sampled on every filtered edge
	always_ff @(posedge clock)
	begin
		if (fall)
			frame <= frame_next;
		if (last_bit)
			scan_code <= frame_next[8:1];	// parity unchecked
	end

endmodule

//--- verilog/key_decoder.sv
// keyboard command decoder
`timescale 1ns/100ps

module key_decoder
(
	input  logic clock,
	input  logic reset,
	input  game_pkg::scan_code_t scan_code,
	input  logic scan_done,
	ship_cmd_if.decoder cmd
);
	import game_pkg::*;

	typedef enum logic {
		KD_IDLE,	// presses
		KD_IGNORE_BREAK	// byte after F0 is a release
	} kd_state_t;

	kd_state_t state;
	dir_t code_dir;	// direction of the current byte, if any

	// wasd and arrows share the map
	always_comb
	begin
		case (scan_code)
			KEY_W, KEY_UP_ARROW:
				code_dir = DIR_UP;
			KEY_D, KEY_RIGHT_ARROW:
				code_dir = DIR_RIGHT;
			KEY_S, KEY_DOWN_ARROW:
				code_dir = DIR_DOWN;
			KEY_A, KEY_LEFT_ARROW:
				code_dir = DIR_LEFT;
			default:
				code_dir = DIR_NONE;
		endcase
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state <= KD_IDLE;
			cmd.held_dir <= DIR_NONE;
			cmd.fire <= 1'b0;
		end
		else
		begin
			cmd.fire <= 1'b0;	// pulse only
			if (scan_done)
			begin
				case (state)
					KD_IDLE:
						if (scan_code == CODE_BREAK)
							state <= KD_IGNORE_BREAK;
						else if (scan_code == KEY_SPACE)
							cmd.fire <= 1'b1;
						else if (code_dir != DIR_NONE)
							cmd.held_dir <= code_dir;	// newest key wins
					KD_IGNORE_BREAK:
						// a stray E0 here keeps waiting for the key byte
						if (scan_code != CODE_EXTEND)
						begin
							state <= KD_IDLE;
							if (code_dir != DIR_NONE && code_dir == cmd.held_dir)
								cmd.held_dir <= DIR_NONE;	// held key let go
						end
					default:
						state <= KD_IDLE;
				endcase
			end
		end
	end

endmodule

//--- verilog/ship_motion.sv
// ship position and heading
`timescale 1ns/100ps

module ship_motion
#(
	parameter int SCREEN_W = 160,
	parameter int SCREEN_H = 120
)
(
	input  logic clock,
	input  logic reset,
	ship_cmd_if.ship cmd,
	sprite_if.ship_src sprite
);
	import game_pkg::*;

	localparam coord_x_t X_MAX  = coord_x_t'(SCREEN_W - 1);
	localparam coord_y_t Y_MAX  = coord_y_t'(SCREEN_H - 1);
	localparam coord_x_t X_HOME = coord_x_t'(SCREEN_W / 2);	// screen centre
	localparam coord_y_t Y_HOME = coord_y_t'(SCREEN_H / 2);

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			sprite.ship_x <= X_HOME;
			sprite.ship_y <= Y_HOME;
			sprite.facing <= DIR_UP;
		end
		else
		begin
			// heading follows the key even between frames
			if (cmd.held_dir != DIR_NONE)
				sprite.facing <= cmd.held_dir;

			// one pixel per frame, stop at the border
			if (cmd.step)
			begin
				case (cmd.held_dir)
					DIR_UP:
						if (sprite.ship_y != '0)
							sprite.ship_y <= sprite.ship_y - 1'b1;	// row 0 at top
					DIR_DOWN:
						if (sprite.ship_y != Y_MAX)
							sprite.ship_y <= sprite.ship_y + 1'b1;
					DIR_LEFT:
						if (sprite.ship_x != '0)
							sprite.ship_x <= sprite.ship_x - 1'b1;
					DIR_RIGHT:
						if (sprite.ship_x != X_MAX)
							sprite.ship_x <= sprite.ship_x + 1'b1;
					default:
						sprite.ship_x <= sprite.ship_x;	// nothing held
				endcase
			end
		end
	end

endmodule

//--- verilog/bullet_motion.sv
// single bullet
`timescale 1ns/100ps

module bullet_motion
#(
	parameter int SCREEN_W = 160,
	parameter int SCREEN_H = 120
)
(
	input  logic clock,
	input  logic reset,
	ship_cmd_if.bullet cmd,
	sprite_if.bullet_src sprite
);
	import game_pkg::*;

	dir_t bullet_dir;	// latched at launch
	coord_x_t next_x;
	coord_y_t next_y;
	logic leaves;	// next move falls off screen
	logic launch;
	logic advance;

	assign launch = cmd.fire && !sprite.bullet_active;	// one bullet at a time
	assign advance = cmd.step && sprite.bullet_active;

	always_comb
	begin
		next_x = sprite.bullet_x;
		next_y = sprite.bullet_y;
		leaves = 1'b0;
		case (bullet_dir)
			DIR_UP:
			begin
				next_y = sprite.bullet_y - coord_y_t'(BULLET_STEP);
				leaves = int'(sprite.bullet_y) < BULLET_STEP;
			end
			DIR_DOWN:
			begin
				next_y = sprite.bullet_y + coord_y_t'(BULLET_STEP);
				leaves = int'(sprite.bullet_y) + BULLET_STEP > SCREEN_H - 1;
			end
			DIR_LEFT:
			begin
				next_x = sprite.bullet_x - coord_x_t'(BULLET_STEP);
				leaves = int'(sprite.bullet_x) < BULLET_STEP;
			end
			DIR_RIGHT:
			begin
				next_x = sprite.bullet_x + coord_x_t'(BULLET_STEP);
				leaves = int'(sprite.bullet_x) + BULLET_STEP > SCREEN_W - 1;
			end
			default:
				leaves = 1'b1;	// no heading, drop it
		endcase
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			sprite.bullet_active <= 1'b0;
		else if (launch)
			sprite.bullet_active <= 1'b1;
		else if (advance && leaves)
			sprite.bullet_active <= 1'b0;	// retired at the edge
	end

	// position and heading
	always_ff @(posedge clock)
	begin
		if (launch)
		begin
			sprite.bullet_x <= sprite.ship_x;	// spawns under the ship
			sprite.bullet_y <= sprite.ship_y;
			bullet_dir <= sprite.facing;
		end
		else if (advance && !leaves)
		begin
			sprite.bullet_x <= next_x;
			sprite.bullet_y <= next_y;
		end
	end

endmodule

//--- verilog/raster_render.sv
// raster scan and pixel colour
`timescale 1ns/100ps

module raster_render
#(
	parameter int SCREEN_W = 160,
	parameter int SCREEN_H = 120
)
(
	input  logic clock,
	input  logic reset,
	sprite_if.render sprite,
	output logic step,	// last pixel of the frame
	output game_pkg::coord_x_t pixel_x,
	output game_pkg::coord_y_t pixel_y,
	output game_pkg::colour_t colour,
	output logic plot
);
	import game_pkg::*;

	localparam coord_x_t X_LAST = coord_x_t'(SCREEN_W - 1);
	localparam coord_y_t Y_LAST = coord_y_t'(SCREEN_H - 1);

	coord_x_t scan_x;	// pixel under the scan
	coord_y_t scan_y;
	logic last_col;
	logic last_row;
	int ship_dx;	// signed offset from ship centre
	int ship_dy;
	logic ship_hit;
	logic bullet_hit;
	colour_t pixel_colour;

	assign last_col = (scan_x == X_LAST);
	assign last_row = (scan_y == Y_LAST);
	assign step = last_col && last_row;	// once per frame

	// row-major, wraps after the last column
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			scan_x <= '0;
			scan_y <= '0;
		end
		else if (last_col)
		begin
			scan_x <= '0;
			if (last_row)
				scan_y <= '0;
			else
				scan_y <= scan_y + 1'b1;
		end
		else
			scan_x <= scan_x + 1'b1;
	end

	always_comb
	begin
		ship_dx = int'(scan_x) - int'(sprite.ship_x);
		ship_dy = int'(scan_y) - int'(sprite.ship_y);

		// plus shape, centre and four neighbours
		ship_hit = (ship_dy == 0 && ship_dx >= -1 && ship_dx <= 1) ||
			(ship_dx == 0 && (ship_dy == -1 || ship_dy == 1));
		bullet_hit = sprite.bullet_active &&
			scan_x == sprite.bullet_x && scan_y == sprite.bullet_y;

		if (ship_hit)
			pixel_colour = COLOUR_SHIP;	// ship drawn over bullet
		else if (bullet_hit)
			pixel_colour = COLOUR_BULLET;
		else
			pixel_colour = COLOUR_BLACK;
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			plot <= 1'b0;
		else
			plot <= 1'b1;	// every pixel written each frame
	end

	// outputs lag the scan by one cycle, all together
	always_ff @(posedge clock)
	begin
		pixel_x <= scan_x;
		pixel_y <= scan_y;
		colour <= pixel_colour;
	end

endmodule

//--- verilog/space_shooter_top.sv
// space shooter top level
`timescale 1ns/100ps

module space_shooter_top
#(
	parameter int SCREEN_W = 160,
	parameter int SCREEN_H = 120
)
(
	input  logic clock,
	input  logic reset,
	input  logic ps2_clock,
	input  logic ps2_data,
	output game_pkg::coord_x_t pixel_x,
	output game_pkg::coord_y_t pixel_y,
	output game_pkg::colour_t colour,
	output logic plot
);
	import game_pkg::*;

	scan_code_t scan_code;
	logic scan_done;
	logic step;	// frame tick from the raster

	ship_cmd_if cmd_bus (.clock(clock), .step(step));
	sprite_if sprite_bus ();

	ps2_rx u_ps2_rx (
		.clock(clock),
		.reset(reset),
		.ps2_clock(ps2_clock),
		.ps2_data(ps2_data),
		.scan_code(scan_code),
		.scan_done(scan_done)
	);

	key_decoder u_key_decoder (
		.clock(clock),
		.reset(reset),
		.scan_code(scan_code),
		.scan_done(scan_done),
		.cmd(cmd_bus.decoder)
	);

	ship_motion #(.SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H)) u_ship_motion (
		.clock(clock),
		.reset(reset),
		.cmd(cmd_bus.ship),
		.sprite(sprite_bus.ship_src)
	);

	bullet_motion #(.SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H)) u_bullet_motion (
		.clock(clock),
		.reset(reset),
		.cmd(cmd_bus.bullet),
		.sprite(sprite_bus.bullet_src)
	);

	raster_render #(.SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H)) u_raster_render (
		.clock(clock),
		.reset(reset),
		.sprite(sprite_bus.render),
		.step(step),
		.pixel_x(pixel_x),
		.pixel_y(pixel_y),
		.colour(colour),
		.plot(plot)
	);

endmodule

//--- tests/space_shooter_tb.sv
// space shooter testbench
`timescale 1ns/100ps

module space_shooter_tb;
	import game_pkg::*;

	localparam int W = 16;	// small screen
	localparam int H = 12;
	localparam int FRAME = W * H;	// cycles per frame
	localparam int PHASE = 20;	// system cycles per ps/2 clock phase

	logic clock;
	logic reset;
	logic ps2_clock;
	logic ps2_data;
	coord_x_t pixel_x;
	coord_y_t pixel_y;
	colour_t colour;
	logic plot;

	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int step_count = 0;	// frame steps so far
	int fire_count = 0;
	int fire_steps = 0;	// step count at the latest fire pulse
	logic [31:0] lfsr_state = 32'hb568_29f8;
	event hang_seen;

	// last captured frame and what it shows
	colour_t pix [0:FRAME-1];
	int frame_steps;	// steps applied to the captured frame
	int ship_x;
	int ship_y;
	int ship_pixels;
	int bullet_pixels;
	int bullet_x;
	int bullet_y;

	space_shooter_top #(.SCREEN_W(W), .SCREEN_H(H)) DUT (
		.clock(clock),
		.reset(reset),
		.ps2_clock(ps2_clock),
		.ps2_data(ps2_data),
		.pixel_x(pixel_x),
		.pixel_y(pixel_y),
		.colour(colour),
		.plot(plot)
	);

	initial
	begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// counted at the falling edge, away from register updates
	always @(negedge clock)
	begin
		if (DUT.step)
			step_count++;
		if (DUT.cmd_bus.fire)
		begin
			fire_count++;
			fire_steps = step_count;	// same-cycle step launches first
		end
	end

	// a stuck wait ends the run here
	initial
	begin
		@(hang_seen);
		$display("SIMULATION FAILED");
		$finish;
	end

	// galois lfsr, one step per bit
	function automatic logic noise_bit();
		logic out;
		out = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out)
			lfsr_state = lfsr_state ^ 32'hb4bc_d35c;
		return out;
	endfunction

	function automatic logic ship_at(int x, int y);
		if (x < 0 || x >= W || y < 0 || y >= H)
			return 1'b1;	// clipped arm counts as ship
		return pix[y * W + x] == COLOUR_SHIP;
	endfunction

	function automatic int clamp(int v, int size);
		return (v < 0) ? 0 : (v > size - 1) ? size - 1 : v;
	endfunction

	task automatic expect_equal(string what, int got, int want);
		assert (got == want)
		else
		begin
			errors++;
			$display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, want);
		end
	endtask

	task automatic give_up(string what);
		$display("timeout waiting for %s", what);
		-> hang_seen;
		wait (1'b0);	// watchdog finishes in this time step
	endtask

	// leaves us just after a rising edge
	task automatic wait_cycles(int n);
		repeat (n)
			@(posedge clock);
		#1;
	endtask

	// start, 8 data lsb first, odd parity, stop
	task automatic send_byte(scan_code_t code);
		logic [10:0] bits;
		bits = {1'b1, ~^code, code, 1'b0};
		for (int i = 0; i < 11; i++)
		begin
			ps2_data = bits[i];	// set up while clock high
			wait_cycles(PHASE);
			ps2_clock = 1'b0;
			wait_cycles(PHASE);
			ps2_clock = 1'b1;
		end
		wait_cycles(PHASE);
	endtask

	// short low pulses with noisy data, below the filter depth
	task automatic clock_glitch();
		repeat (2)
		begin
			ps2_clock = 1'b0;
			repeat (3)
			begin
				ps2_data = noise_bit();
				wait_cycles(1);
			end
			ps2_clock = 1'b1;
			repeat (3)
			begin
				ps2_data = noise_bit();
				wait_cycles(1);
			end
		end
		ps2_data = 1'b1;
		wait_cycles(PHASE);
	endtask

	task automatic wait_steps(int n);
		int target;
		int waited;
		target = step_count + n;
		waited = 0;
		while (step_count < target && waited < (n + 1) * FRAME)
		begin
			wait_cycles(1);
			waited++;
		end
		if (step_count < target)
			give_up("frame steps");
	endtask

	// next full frame after a step, checked for raster order
	task automatic capture_frame();
		int waited;
		waited = 0;
		while (DUT.step !== 1'b1 && waited < 2 * FRAME)
		begin
			wait_cycles(1);
			waited++;
		end
		if (DUT.step !== 1'b1)
			give_up("frame step");
		wait_cycles(1);	// old frame's last pixel on the outputs
		frame_steps = step_count;
		for (int i = 0; i < FRAME; i++)
		begin
			wait_cycles(1);
			expect_equal("plot", plot, 1);
			expect_equal("pixel_x", pixel_x, i % W);
			expect_equal("pixel_y", pixel_y, i / W);
			pix[i] = colour;
		end
		ship_pixels = 0;
		bullet_pixels = 0;
		ship_x = -1;
		ship_y = -1;
		for (int y = 0; y < H; y++)
			for (int x = 0; x < W; x++)
			begin
				if (pix[y * W + x] == COLOUR_SHIP)
				begin
					ship_pixels++;
					// centre has ship on both axes
					if (ship_at(x - 1, y) && ship_at(x + 1, y) &&
						ship_at(x, y - 1) && ship_at(x, y + 1))
					begin
						ship_x = x;
						ship_y = y;
					end
				end
				else if (pix[y * W + x] == COLOUR_BULLET)
				begin
					bullet_pixels++;
					bullet_x = x;
					bullet_y = y;
				end
			end
	endtask

	// one pixel per step since the reference capture, clamped
	task automatic track_motion(int dx, int dy, int frames);
		int x0;
		int y0;
		int s0;
		capture_frame();
		repeat (frames)
		begin
			x0 = ship_x;
			y0 = ship_y;
			s0 = frame_steps;
			capture_frame();
			expect_equal("ship column", ship_x, clamp(x0 + dx * (frame_steps - s0), W));
			expect_equal("ship row", ship_y, clamp(y0 + dy * (frame_steps - s0), H));
		end
	endtask

	task automatic end_test(string name, int errors_before);
		tests_run++;
		if (errors == errors_before)
			$display("test %s: ok", name);
		else
		begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - errors_before);
		end
	endtask

	task automatic test_reset_raster();
		int e;
		e = errors;
		reset = 1'b1;
		repeat (8)
		begin
			wait_cycles(1);
			expect_equal("plot in reset", plot, 0);
		end
		reset = 1'b0;
		capture_frame();
		expect_equal("ship column", ship_x, W / 2);
		expect_equal("ship row", ship_y, H / 2);
		expect_equal("ship pixels", ship_pixels, 5);
		expect_equal("bullet pixels", bullet_pixels, 0);
		end_test("reset_raster", e);
	endtask

	task automatic test_move_release();
		int e;
		e = errors;
		send_byte(CODE_EXTEND);
		send_byte(KEY_LEFT_ARROW);
		track_motion(-1, 0, 2);
		send_byte(CODE_EXTEND);
		send_byte(CODE_BREAK);
		send_byte(KEY_LEFT_ARROW);	// left edge reached by now
		send_byte(KEY_D);
		track_motion(1, 0, 2);
		send_byte(CODE_BREAK);
		send_byte(KEY_D);
		track_motion(0, 0, 1);	// released, stays put
		end_test("move_release", e);
	endtask

	task automatic test_border_clamp();
		int e;
		e = errors;
		send_byte(KEY_A);
		wait_steps(W + 4);
		capture_frame();
		expect_equal("ship column", ship_x, 0);
		expect_equal("ship row", ship_y, H / 2);
		expect_equal("ship pixels", ship_pixels, 4);	// left arm off screen
		expect_equal("right arm", pix[(H / 2) * W + 1], COLOUR_SHIP);
		send_byte(CODE_BREAK);
		send_byte(KEY_A);
		end_test("border_clamp", e);
	endtask

	task automatic test_fire();
		int e;
		int sx;
		int sy;
		int launch;
		int fires;
		int k;
		int gone;
		int frames;
		e = errors;
		send_byte(KEY_S);	// bottom row first, room to fly
		wait_steps(H);
		send_byte(CODE_BREAK);
		send_byte(KEY_S);
		send_byte(KEY_W);	// face up
		send_byte(CODE_BREAK);
		send_byte(KEY_W);
		capture_frame();
		sx = ship_x;
		sy = ship_y;
		fires = fire_count;
		send_byte(KEY_SPACE);
		launch = fire_steps;
		send_byte(KEY_SPACE);	// bullet still in flight here
		expect_equal("fire pulses", fire_count, fires + 2);
		gone = 0;
		frames = 0;
		while (!gone && frames < 2 * H)
		begin
			capture_frame();
			frames++;
			k = frame_steps - launch;
			expect_equal("ship row", ship_y, sy);
			if (sy - 2 * k >= 0)
			begin
				expect_equal("bullet pixels", bullet_pixels, 1);
				expect_equal("bullet column", bullet_x, sx);
				expect_equal("bullet row", bullet_y, sy - 2 * k);
			end
			else
			begin
				expect_equal("bullet pixels past row 0", bullet_pixels, 0);
				gone = 1;
			end
		end
		expect_equal("bullet retired", gone, 1);
		end_test("fire", e);
	endtask

	task automatic test_break_noise();
		int e;
		int fires;
		e = errors;
		fires = fire_count;
		send_byte(CODE_BREAK);
		clock_glitch();
		send_byte(KEY_SPACE);	// release only
		expect_equal("fire pulses", fire_count, fires);
		clock_glitch();
		send_byte(KEY_D);
		send_byte(CODE_BREAK);
		send_byte(KEY_A);	// not the held key
		track_motion(1, 0, 1);
		send_byte(CODE_BREAK);
		send_byte(KEY_D);
		track_motion(0, 0, 1);
		clock_glitch();
		send_byte(KEY_W);
		clock_glitch();
		track_motion(0, -1, 2);
		end_test("break_noise", e);
	endtask

	initial
	begin
		reset = 1'b1;
		ps2_clock = 1'b1;	// idle bus
		ps2_data = 1'b1;
		test_reset_raster();
		test_move_release();
		test_border_clamp();
		test_fire();
		test_break_noise();
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- space_shooter.f
verilog/game_pkg.sv
verilog/ship_cmd_if.sv
verilog/sprite_if.sv
verilog/ps2_rx.sv
verilog/key_decoder.sv
verilog/ship_motion.sv
verilog/bullet_motion.sv
verilog/raster_render.sv
verilog/space_shooter_top.sv
tests/space_shooter_tb.sv
